/* hw/axi_apb_pkg.sv */
`default_nettype none

package axi_apb_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = 4;
	localparam int num_slaves = 4;

	// Slave i owns 0x1000*i up to 0x1000*i + 0xFF.
	localparam logic [num_slaves-1:0][addr_w-1:0] slave_base = {
		32'h0000_3000,
		32'h0000_2000,
		32'h0000_1000,
		32'h0000_0000
	};

	localparam logic [num_slaves-1:0][addr_w-1:0] slave_limit = {
		32'h0000_30FF,
		32'h0000_20FF,
		32'h0000_10FF,
		32'h0000_00FF
	};

	// Access cycles without pready before the transfer is abandoned.
	localparam int timeout_cycles = 16;
	localparam int timeout_w = $clog2(timeout_cycles);

	typedef enum logic [1:0] {
		resp_okay   = 2'd0,
		resp_slverr = 2'd2
	} resp_e;

	typedef enum logic [2:0] {
		st_idle,
		st_wait_wdata,
		st_wait_waddr,
		st_setup,
		st_access,
		st_resp
	} bridge_state_e;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
		logic [strb_w-1:0] strb;
		logic              write;
	} apb_req_t;

	typedef struct packed {
		logic              valid;
		logic              error;
		logic [data_w-1:0] rdata;
	} apb_done_t;

	typedef logic [num_slaves-1:0][data_w-1:0] prdata_arr_t;

endpackage

`default_nettype wire

/* hw/bridge_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module bridge_ctrl (
	input  wire logic                   s_axi_clk,
	input  wire logic                   s_axi_aresetn,
	input  wire logic                   arvalid,
	input  wire logic                   awvalid,
	input  wire logic                   wvalid,
	input  wire logic                   resp_pending,
	input  wire axi_apb_pkg::apb_done_t done,
	output logic                        arready,
	output logic                        awready,
	output logic                        wready,
	output logic                        ld_read,
	output logic                        ld_waddr,
	output logic                        ld_wdata,
	output logic                        setup,
	output logic                        access
);

	axi_apb_pkg::bridge_state_e state;
	axi_apb_pkg::bridge_state_e state_nxt;
	logic                       idle_free;

	// New requests only while nothing is in flight or waiting.
	assign idle_free = (state == axi_apb_pkg::st_idle) && !resp_pending;

	// Read wins over a write offered in the same cycle.
	assign arready = idle_free;
	assign awready = (idle_free && !arvalid) || (state == axi_apb_pkg::st_wait_waddr);
	assign wready  = (idle_free && !arvalid) || (state == axi_apb_pkg::st_wait_wdata);

	assign ld_read  = arvalid && arready;
	assign ld_waddr = awvalid && awready;
	assign ld_wdata = wvalid && wready;

	assign setup  = (state == axi_apb_pkg::st_setup);
	assign access = (state == axi_apb_pkg::st_access);

	always_comb begin
		state_nxt = state;
		case (state)
			axi_apb_pkg::st_idle: begin
				if (!resp_pending) begin
					if (arvalid) begin
						state_nxt = axi_apb_pkg::st_setup;
					end else if (awvalid && wvalid) begin
						state_nxt = axi_apb_pkg::st_setup;
					end else if (awvalid) begin
						state_nxt = axi_apb_pkg::st_wait_wdata;
					end else if (wvalid) begin
						state_nxt = axi_apb_pkg::st_wait_waddr;
					end
				end
			end
			axi_apb_pkg::st_wait_wdata: begin
				if (wvalid) begin
					state_nxt = axi_apb_pkg::st_setup;
				end
			end
			axi_apb_pkg::st_wait_waddr: begin
				if (awvalid) begin
					state_nxt = axi_apb_pkg::st_setup;
				end
			end
			axi_apb_pkg::st_setup: begin
				state_nxt = axi_apb_pkg::st_access;
			end
			axi_apb_pkg::st_access: begin
				if (done.valid) begin
					state_nxt = axi_apb_pkg::st_resp;
				end
			end
			axi_apb_pkg::st_resp: begin
				// Wait for the master to take the response.
				if (!resp_pending) begin
					state_nxt = axi_apb_pkg::st_idle;
				end
			end
			default: begin
				state_nxt = axi_apb_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			state <= axi_apb_pkg::st_idle;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

`default_nettype wire

/* hw/request_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module request_capture (
	input  wire logic                             s_axi_clk,
	input  wire logic                             s_axi_aresetn,
	input  wire logic [axi_apb_pkg::addr_w-1:0]   araddr,
	input  wire logic [axi_apb_pkg::addr_w-1:0]   awaddr,
	input  wire logic [axi_apb_pkg::data_w-1:0]   wdata,
	input  wire logic [axi_apb_pkg::strb_w-1:0]   wstrb,
	input  wire logic                             ld_read,
	input  wire logic                             ld_waddr,
	input  wire logic                             ld_wdata,
	output axi_apb_pkg::apb_req_t                 req
);

	logic [axi_apb_pkg::addr_w-1:0] addr_q;
	logic [axi_apb_pkg::data_w-1:0] wdata_q;
	logic [axi_apb_pkg::strb_w-1:0] strb_q;
	logic                           write_q;

	always_ff @(posedge s_axi_clk) begin
		if (ld_read) begin
			addr_q <= araddr;
		end else if (ld_waddr) begin
			addr_q <= awaddr;
		end
		if (ld_wdata) begin
			wdata_q <= wdata;
			strb_q  <= wstrb;
		end
	end

	// Direction of the request held for the APB and response stages.
	always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			write_q <= 1'b0;
		end else if (ld_read) begin
			write_q <= 1'b0;
		end else if (ld_waddr) begin
			write_q <= 1'b1;
		end
	end

	assign req = '{addr: addr_q, wdata: wdata_q, strb: strb_q, write: write_q};

endmodule

`default_nettype wire

/* hw/apb_port.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_port (
	input  wire logic                               s_axi_clk,
	input  wire logic                               s_axi_aresetn,
	input  wire axi_apb_pkg::apb_req_t              req,
	input  wire logic                               setup,
	input  wire logic                               access,
	input  wire logic [axi_apb_pkg::num_slaves-1:0] m_apb_pready,
	input  wire axi_apb_pkg::prdata_arr_t           m_apb_prdata,
	input  wire logic [axi_apb_pkg::num_slaves-1:0] m_apb_pslverr,
	output logic [axi_apb_pkg::addr_w-1:0]          m_apb_paddr,
	output logic [axi_apb_pkg::num_slaves-1:0]      m_apb_psel,
	output logic                                    m_apb_penable,
	output logic                                    m_apb_pwrite,
	output logic [axi_apb_pkg::data_w-1:0]          m_apb_pwdata,
	output logic [axi_apb_pkg::strb_w-1:0]          m_apb_pstrb,
	output axi_apb_pkg::apb_done_t                  done
);

	logic [axi_apb_pkg::num_slaves-1:0] hit;
	logic [axi_apb_pkg::data_w-1:0]     sel_rdata;
	logic                               sel_ready;
	logic                               sel_err;
	logic                               timeout;
	logic [axi_apb_pkg::timeout_w-1:0]  wait_cnt;

	// An unmapped address selects nothing and runs into the timeout.
	always_comb begin
		for (int i = 0; i < axi_apb_pkg::num_slaves; i++) begin
			hit[i] = (req.addr >= axi_apb_pkg::slave_base[i]) &&
				(req.addr <= axi_apb_pkg::slave_limit[i]);
		end
	end

	assign m_apb_psel    = hit & {axi_apb_pkg::num_slaves{setup || access}};
	// Enable only toward a selected slave.
	assign m_apb_penable = access && (|hit);
	assign m_apb_paddr   = req.addr;
	assign m_apb_pwrite  = req.write;
	assign m_apb_pwdata  = req.wdata;
	assign m_apb_pstrb   = req.write ? req.strb : '0;

	always_comb begin
		sel_rdata = '0;
		for (int i = 0; i < axi_apb_pkg::num_slaves; i++) begin
			if (m_apb_psel[i]) begin
				sel_rdata = sel_rdata | m_apb_prdata[i];
			end
		end
	end

	assign sel_ready = |(m_apb_psel & m_apb_pready);
	assign sel_err   = |(m_apb_psel & m_apb_pslverr);
	assign timeout   = access && !sel_ready &&
		(wait_cnt == axi_apb_pkg::timeout_w'(axi_apb_pkg::timeout_cycles - 1));

	always_comb begin
		done.valid = access && (sel_ready || timeout);
		done.error = sel_ready ? sel_err : timeout;
		done.rdata = sel_ready ? sel_rdata : '0;
	end

	// Access cycles spent waiting on pready.
	always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			wait_cnt <= '0;
		end else if (access && !done.valid) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else begin
			wait_cnt <= '0;
		end
	end

endmodule

`default_nettype wire

/* hw/response_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module response_regs (
	input  wire logic                       s_axi_clk,
	input  wire logic                       s_axi_aresetn,
	input  wire axi_apb_pkg::apb_done_t     done,
	input  wire axi_apb_pkg::apb_req_t      req,
	input  wire logic                       rready,
	input  wire logic                       bready,
	output logic                            rvalid,
	output logic [axi_apb_pkg::data_w-1:0]  rdata,
	output axi_apb_pkg::resp_e              rresp,
	output logic                            bvalid,
	output axi_apb_pkg::resp_e              bresp,
	output logic                            resp_pending
);

	axi_apb_pkg::resp_e done_resp;

	assign done_resp = done.error ? axi_apb_pkg::resp_slverr : axi_apb_pkg::resp_okay;
	assign resp_pending = rvalid || bvalid;

	always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (done.valid && !req.write) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (done.valid && req.write) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Payload only changes on a completion, never while a response waits.
	always_ff @(posedge s_axi_clk) begin
		if (done.valid) begin
			if (req.write) begin
				bresp <= done_resp;
			end else begin
				rresp <= done_resp;
				rdata <= done.rdata;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/axi_apb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_apb_bridge (
	input  wire logic                                 s_axi_clk,
	input  wire logic                                 s_axi_aresetn,
	input  wire logic [axi_apb_pkg::addr_w-1:0]       s_axi_awaddr,
	input  wire logic                                 s_axi_awvalid,
	output logic                                      s_axi_awready,
	input  wire logic [axi_apb_pkg::data_w-1:0]       s_axi_wdata,
	input  wire logic                                 s_axi_wvalid,
	input  wire logic [axi_apb_pkg::strb_w-1:0]       s_axi_wstrb,
	output logic                                      s_axi_wready,
	output logic [1:0]                                s_axi_bresp,
	output logic                                      s_axi_bvalid,
	input  wire logic                                 s_axi_bready,
	input  wire logic [axi_apb_pkg::addr_w-1:0]       s_axi_araddr,
	input  wire logic                                 s_axi_arvalid,
	output logic                                      s_axi_arready,
	output logic [1:0]                                s_axi_rresp,
	output logic                                      s_axi_rvalid,
	output logic [axi_apb_pkg::data_w-1:0]            s_axi_rdata,
	input  wire logic                                 s_axi_rready,
	output logic [axi_apb_pkg::addr_w-1:0]            m_apb_paddr,
	output logic [axi_apb_pkg::num_slaves-1:0]        m_apb_psel,
	output logic                                      m_apb_penable,
	output logic                                      m_apb_pwrite,
	output logic [axi_apb_pkg::data_w-1:0]            m_apb_pwdata,
	output logic [axi_apb_pkg::strb_w-1:0]            m_apb_pstrb,
	input  wire logic [axi_apb_pkg::num_slaves-1:0]   m_apb_pready,
	input  wire axi_apb_pkg::prdata_arr_t             m_apb_prdata,
	input  wire logic [axi_apb_pkg::num_slaves-1:0]   m_apb_pslverr
);

	logic                   ld_read;
	logic                   ld_waddr;
	logic                   ld_wdata;
	logic                   setup;
	logic                   access;
	logic                   resp_pending;
	axi_apb_pkg::apb_req_t  req;
	axi_apb_pkg::apb_done_t done;

	bridge_ctrl u_ctrl (
		.s_axi_clk     (s_axi_clk),
		.s_axi_aresetn (s_axi_aresetn),
		.arvalid       (s_axi_arvalid),
		.awvalid       (s_axi_awvalid),
		.wvalid        (s_axi_wvalid),
		.resp_pending  (resp_pending),
		.done          (done),
		.arready       (s_axi_arready),
		.awready       (s_axi_awready),
		.wready        (s_axi_wready),
		.ld_read       (ld_read),
		.ld_waddr      (ld_waddr),
		.ld_wdata      (ld_wdata),
		.setup         (setup),
		.access        (access)
	);

	request_capture u_capture (
		.s_axi_clk     (s_axi_clk),
		.s_axi_aresetn (s_axi_aresetn),
		.araddr        (s_axi_araddr),
		.awaddr        (s_axi_awaddr),
		.wdata         (s_axi_wdata),
		.wstrb         (s_axi_wstrb),
		.ld_read       (ld_read),
		.ld_waddr      (ld_waddr),
		.ld_wdata      (ld_wdata),
		.req           (req)
	);

	apb_port u_apb (
		.s_axi_clk     (s_axi_clk),
		.s_axi_aresetn (s_axi_aresetn),
		.req           (req),
		.setup         (setup),
		.access        (access),
		.m_apb_pready  (m_apb_pready),
		.m_apb_prdata  (m_apb_prdata),
		.m_apb_pslverr (m_apb_pslverr),
		.m_apb_paddr   (m_apb_paddr),
		.m_apb_psel    (m_apb_psel),
		.m_apb_penable (m_apb_penable),
		.m_apb_pwrite  (m_apb_pwrite),
		.m_apb_pwdata  (m_apb_pwdata),
		.m_apb_pstrb   (m_apb_pstrb),
		.done          (done)
	);

	response_regs u_resp (
		.s_axi_clk     (s_axi_clk),
		.s_axi_aresetn (s_axi_aresetn),
		.done          (done),
		.req           (req),
		.rready        (s_axi_rready),
		.bready        (s_axi_bready),
		.rvalid        (s_axi_rvalid),
		.rdata         (s_axi_rdata),
		.rresp         (s_axi_rresp),
		.bvalid        (s_axi_bvalid),
		.bresp         (s_axi_bresp),
		.resp_pending  (resp_pending)
	);

endmodule

`default_nettype wire

/* test/apb_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_slave_model (
	input  wire logic                               s_axi_clk,
	input  wire logic                               s_axi_aresetn,
	input  wire logic [axi_apb_pkg::addr_w-1:0]     m_apb_paddr,
	input  wire logic [axi_apb_pkg::num_slaves-1:0] m_apb_psel,
	input  wire logic                               m_apb_penable,
	input  wire logic                               m_apb_pwrite,
	input  wire logic [axi_apb_pkg::data_w-1:0]     m_apb_pwdata,
	input  wire logic [axi_apb_pkg::strb_w-1:0]     m_apb_pstrb,
	output logic [axi_apb_pkg::num_slaves-1:0]      m_apb_pready,
	output axi_apb_pkg::prdata_arr_t                m_apb_prdata,
	output logic [axi_apb_pkg::num_slaves-1:0]      m_apb_pslverr
);

	logic [7:0] mem [axi_apb_pkg::num_slaves][256];
	logic [1:0] wait_cnt [axi_apb_pkg::num_slaves];
	logic [7:0] word_base;

	assign word_base = {m_apb_paddr[7:2], 2'b00};

	// Start-up contents follow the full byte address.
	initial begin
		logic [15:0] a;
		for (int s = 0; s < axi_apb_pkg::num_slaves; s++) begin
			for (int b = 0; b < 256; b++) begin
				a = 16'(s * 16'h1000 + b);
				mem[s][b] = a[7:0] ^ a[15:8] ^ 8'h5A;
			end
		end
	end

	// Slave s answers after s wait states.
	always_comb begin
		for (int s = 0; s < axi_apb_pkg::num_slaves; s++) begin
			m_apb_pready[s]  = m_apb_psel[s] && m_apb_penable && (wait_cnt[s] == 2'(s));
			m_apb_pslverr[s] = m_apb_psel[s] && m_apb_penable && (m_apb_paddr[7:0] == 8'hFC);
			for (int b = 0; b < 4; b++) begin
				m_apb_prdata[s][8*b +: 8] = mem[s][word_base + 8'(b)];
			end
		end
	end

	always_ff @(posedge s_axi_clk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			for (int s = 0; s < axi_apb_pkg::num_slaves; s++) begin
				wait_cnt[s] <= '0;
			end
		end else begin
			for (int s = 0; s < axi_apb_pkg::num_slaves; s++) begin
				if (m_apb_psel[s] && m_apb_penable && !m_apb_pready[s]) begin
					wait_cnt[s] <= wait_cnt[s] + 2'd1;
				end else begin
					wait_cnt[s] <= '0;
				end
			end
		end
	end

	// Erroring writes leave the memory alone.
	always @(posedge s_axi_clk) begin
		for (int s = 0; s < axi_apb_pkg::num_slaves; s++) begin
			if (m_apb_pready[s] && m_apb_pwrite && !m_apb_pslverr[s]) begin
				for (int b = 0; b < 4; b++) begin
					if (m_apb_pstrb[b]) begin
						mem[s][word_base + 8'(b)] <= m_apb_pwdata[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* test/bridge_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module bridge_properties (
	input wire logic                               s_axi_clk,
	input wire logic                               s_axi_aresetn,
	input wire logic [axi_apb_pkg::num_slaves-1:0] m_apb_psel,
	input wire logic                               m_apb_penable,
	input wire logic [axi_apb_pkg::addr_w-1:0]     m_apb_paddr,
	input wire logic                               s_axi_rvalid,
	input wire logic                               s_axi_rready,
	input wire logic [axi_apb_pkg::data_w-1:0]     s_axi_rdata,
	input wire logic [1:0]                         s_axi_rresp,
	input wire logic                               s_axi_bvalid,
	input wire logic                               s_axi_bready,
	input wire logic [1:0]                         s_axi_bresp
);

	int fails = 0;

	penable_psel: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
		m_apb_penable |-> (m_apb_psel != '0))
		else begin
			$error("penable high with no psel");
			fails++;
		end

	psel_onehot: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
		$onehot0(m_apb_psel))
		else begin
			$error("psel has more than one bit set");
			fails++;
		end

	paddr_stable: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
		m_apb_penable |-> $stable(m_apb_paddr))
		else begin
			$error("paddr changed between setup and access");
			fails++;
		end

	rvalid_held: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
		s_axi_rvalid && !s_axi_rready |=>
			s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp))
		else begin
			$error("read response dropped or changed before rready");
			fails++;
		end

	bvalid_held: assert property (@(posedge s_axi_clk) disable iff (!s_axi_aresetn)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
		else begin
			$error("write response dropped or changed before bready");
			fails++;
		end

endmodule

bind axi_apb_bridge bridge_properties u_props (.*);

`default_nettype wire

/* test/tb_axi_apb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_apb_bridge;

	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
		logic [1:0]  resp;
		logic [31:0] rdata;
	} result_t;

	typedef struct packed {
		logic        check_data;
		logic [1:0]  resp;
		logic [31:0] rdata;
	} expect_t;

	localparam int wait_limit = 200;

	logic        s_axi_clk;
	logic        s_axi_aresetn;
	logic [31:0] s_axi_awaddr;
	logic        s_axi_awvalid;
	logic        s_axi_awready;
	logic [31:0] s_axi_wdata;
	logic        s_axi_wvalid;
	logic [3:0]  s_axi_wstrb;
	logic        s_axi_wready;
	logic [1:0]  s_axi_bresp;
	logic        s_axi_bvalid;
	logic        s_axi_bready;
	logic [31:0] s_axi_araddr;
	logic        s_axi_arvalid;
	logic        s_axi_arready;
	logic [1:0]  s_axi_rresp;
	logic        s_axi_rvalid;
	logic [31:0] s_axi_rdata;
	logic        s_axi_rready;
	logic [31:0] m_apb_paddr;
	logic [3:0]  m_apb_psel;
	logic        m_apb_penable;
	logic        m_apb_pwrite;
	logic [31:0] m_apb_pwdata;
	logic [3:0]  m_apb_pstrb;
	logic [3:0]  m_apb_pready;
	logic [3:0]  m_apb_pslverr;
	axi_apb_pkg::prdata_arr_t m_apb_prdata;

	logic [31:0] lfsr = 32'h9367_7e6d;
	logic [31:0] shadow [logic [31:0]];
	result_t     results [$];
	string       test_names [6] = '{"full_words", "strobes", "pslverr", "unmapped",
		"write_order", "backpressure"};
	int          cur_test = 0;
	int          checks = 0;
	int          errors = 0;
	int          test_checks = 0;
	int          test_errors = 0;

	axi_apb_bridge uut (.*);
	apb_slave_model u_slaves (.*);

	initial begin
		s_axi_clk = 1'b0;
		forever #5 s_axi_clk = ~s_axi_clk;
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wdata,
		logic [3:0] strb);
		logic [31:0] m;
		m = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				m[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return m;
	endfunction

	// Expected response from the address map, the 0xFC error rule and the shadow memory.
	function automatic expect_t predict(result_t r);
		expect_t e;
		logic    mapped;
		mapped = 1'b0;
		for (int i = 0; i < axi_apb_pkg::num_slaves; i++) begin
			if (r.addr >= axi_apb_pkg::slave_base[i] && r.addr <= axi_apb_pkg::slave_limit[i]) begin
				mapped = 1'b1;
			end
		end
		e = '{check_data: !r.write, resp: axi_apb_pkg::resp_okay, rdata: '0};
		if (!mapped) begin
			e.resp = axi_apb_pkg::resp_slverr;
		end else if (r.addr[7:0] == 8'hFC) begin
			e.resp = axi_apb_pkg::resp_slverr;
			e.check_data = 1'b0;
		end else if (!r.write) begin
			e.rdata = shadow.exists(r.addr) ? shadow[r.addr] : '0;
		end
		return e;
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		test_checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", test_names[cur_test], what,
				exp, got);
			errors++;
			test_errors++;
		end
	endtask

	task automatic give_up(input string why);
		$display("ERROR: timed out while %s", why);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	initial begin
		result_t r;
		expect_t e;
		forever begin
			@(posedge s_axi_clk);
			while (results.size() > 0) begin
				r = results.pop_front();
				e = predict(r);
				check_value($sformatf("resp @%h", r.addr), 32'(e.resp), 32'(r.resp));
				if (e.check_data) begin
					check_value($sformatf("rdata @%h", r.addr), e.rdata, r.rdata);
				end
				if (r.write && e.resp == axi_apb_pkg::resp_okay) begin
					shadow[r.addr] = merge_bytes(shadow.exists(r.addr) ? shadow[r.addr] : '0,
						r.wdata, r.strb);
				end
			end
		end
	end

	// Ready held low; the response and the bridge must both stay put.
	task automatic hold_response(input logic is_read, input int cycles);
		logic [31:0] data0;
		logic [1:0]  resp0;
		data0 = s_axi_rdata;
		resp0 = is_read ? s_axi_rresp : s_axi_bresp;
		repeat (cycles) begin
			@(posedge s_axi_clk);
			check_value("valid held", 32'h1, 32'(is_read ? s_axi_rvalid : s_axi_bvalid));
			check_value("resp held", 32'(resp0), 32'(is_read ? s_axi_rresp : s_axi_bresp));
			if (is_read) begin
				check_value("rdata held", data0, s_axi_rdata);
			end
			check_value("readies low", 32'h0, 32'({s_axi_arready, s_axi_awready, s_axi_wready}));
		end
	endtask

	task automatic take_response(input logic is_read, input int hold, inout result_t r);
		int n;
		n = 0;
		while (!(is_read ? s_axi_rvalid : s_axi_bvalid)) begin
			@(posedge s_axi_clk);
			n++;
			if (n > wait_limit) begin
				give_up("waiting for a response");
			end
		end
		hold_response(is_read, hold);
		if (is_read) begin
			s_axi_rready <= 1'b1;
		end else begin
			s_axi_bready <= 1'b1;
		end
		@(posedge s_axi_clk);
		check_value("valid at handshake", 32'h1, 32'(is_read ? s_axi_rvalid : s_axi_bvalid));
		r.resp = is_read ? s_axi_rresp : s_axi_bresp;
		r.rdata = s_axi_rdata;
		s_axi_rready <= 1'b0;
		s_axi_bready <= 1'b0;
		results.push_back(r);
	endtask

	// Order 0 offers address and data together, 1 address first, 2 data first.
	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int order, input int hold);
		result_t r;
		int      n;
		logic    aw_done;
		logic    w_done;
		r = '{write: 1'b1, addr: addr, wdata: data, strb: strb, resp: '0, rdata: '0};
		n = 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		s_axi_awaddr <= addr;
		s_axi_wdata <= data;
		s_axi_wstrb <= strb;
		s_axi_awvalid <= (order != 2);
		s_axi_wvalid <= (order != 1);
		while (!(aw_done && w_done)) begin
			@(posedge s_axi_clk);
			n++;
			if (n > wait_limit) begin
				give_up("offering a write");
			end
			if (s_axi_awvalid && s_axi_awready) begin
				aw_done = 1'b1;
				s_axi_awvalid <= 1'b0;
				if (order == 1) begin
					s_axi_wvalid <= 1'b1;
				end
			end
			if (s_axi_wvalid && s_axi_wready) begin
				w_done = 1'b1;
				s_axi_wvalid <= 1'b0;
				if (order == 2) begin
					s_axi_awvalid <= 1'b1;
				end
			end
		end
		take_response(1'b0, hold, r);
	endtask

	task automatic axi_read(input logic [31:0] addr, input int hold);
		result_t r;
		int      n;
		r = '{write: 1'b0, addr: addr, wdata: '0, strb: '0, resp: '0, rdata: '0};
		n = 0;
		s_axi_araddr <= addr;
		s_axi_arvalid <= 1'b1;
		do begin
			@(posedge s_axi_clk);
			n++;
			if (n > wait_limit) begin
				give_up("waiting for arready");
			end
		end while (!s_axi_arready);
		s_axi_arvalid <= 1'b0;
		take_response(1'b1, hold, r);
	endtask

	task automatic start_test(input int idx);
		cur_test = idx;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic finish_test();
		int n;
		n = 0;
		while (results.size() != 0) begin
			@(posedge s_axi_clk);
			n++;
			if (n > wait_limit) begin
				give_up("draining the compare queue");
			end
		end
		$display("test %0d %-12s %0d checks, %0d errors", cur_test + 1, test_names[cur_test],
			test_checks, test_errors);
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] bits;
		logic [31:0] addrs [$];
		s_axi_aresetn = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wvalid = 1'b0;
		s_axi_wstrb = '0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		repeat (5) @(posedge s_axi_clk);
		s_axi_aresetn <= 1'b1;
		@(posedge s_axi_clk);

		start_test(0);
		for (int s = 0; s < 4; s++) begin
			for (int k = 0; k < 4; k++) begin
				random_bits(3, bits);
				addr = axi_apb_pkg::slave_base[s] + 32'((k * 8 + bits) * 4);
				random_bits(32, data);
				axi_write(addr, data, 4'hF, 0, 0);
				addrs.push_back(addr);
			end
		end
		foreach (addrs[i]) begin
			axi_read(addrs[i], 0);
		end
		finish_test();

		start_test(1);
		for (int s = 0; s < 4; s++) begin
			addr = axi_apb_pkg::slave_base[s] + 32'h80 + 32'(s * 4);
			random_bits(32, data);
			axi_write(addr, data, 4'hF, 0, 0);
			repeat (3) begin
				random_bits(32, data);
				random_bits(4, bits);
				axi_write(addr, data, bits[3:0], 0, 0);
				axi_read(addr, 0);
			end
		end
		finish_test();

		start_test(2);
		axi_write(32'h0000_20FC, 32'hDEAD_BEEF, 4'hF, 0, 0);
		axi_read(32'h0000_20FC, 0);
		axi_read(32'h0000_00FC, 0);
		finish_test();

		start_test(3);
		axi_write(32'h0000_8000, 32'h1234_5678, 4'hF, 0, 0);
		axi_read(32'h0000_8000, 0);
		finish_test();

		start_test(4);
		random_bits(32, data);
		for (int order = 0; order < 3; order++) begin
			addr = axi_apb_pkg::slave_base[3] + 32'hA0 + 32'(order * 4);
			axi_write(addr, data, 4'hF, order, 0);
			axi_read(addr, 0);
		end
		finish_test();

		start_test(5);
		for (int k = 0; k < 6; k++) begin
			addr = axi_apb_pkg::slave_base[k % 4] + 32'hC0;
			random_bits(32, data);
			random_bits(3, bits);
			axi_write(addr, data, 4'hF, k % 3, 1 + int'(bits));
			random_bits(3, bits);
			axi_read(addr, 1 + int'(bits));
		end
		finish_test();

		$display("summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
			uut.u_props.fails);
		if (errors == 0 && uut.u_props.fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
hw/axi_apb_pkg.sv
hw/bridge_ctrl.sv
hw/request_capture.sv
hw/apb_port.sv
hw/response_regs.sv
hw/axi_apb_bridge.sv
test/apb_slave_model.sv
test/bridge_properties.sv
test/tb_axi_apb_bridge.sv

/* Bender.yml */
package:
  name: axi_apb_bridge

sources:
  - hw/axi_apb_pkg.sv
  - hw/bridge_ctrl.sv
  - hw/request_capture.sv
  - hw/apb_port.sv
  - hw/response_regs.sv
  - hw/axi_apb_bridge.sv
  - target: test
    files:
      - test/apb_slave_model.sv
      - test/bridge_properties.sv
      - test/tb_axi_apb_bridge.sv
